// File: design/oram_defs.svh
`ifndef ORAM_DEFS_SVH
`define ORAM_DEFS_SVH

// ========================================
// address and leaf widths
// ========================================
`define ORAMU          10
`define ORAML          8
`define TAGWIDTH       (`ORAMU - 2)
`define CMDWIDTH       2
`define FEDWIDTH       32

// position map layout
`define LEAFINBLOCK    4
`define LEAFIDXW       2
`define NUMVALIDBLOCK  1024
`define PMBLOCKS       (1 << `TAGWIDTH)

// PLB geometry
`define PLBWAYS        4
`define WAYIDXW        2

// backend command codes
`define CMDWRITE       2'd0
`define CMDREAD        2'd1
`define CMDREADRMV     2'd2
`define CMDAPPEND      2'd3

// leaf generator
`define LFSRSEED       16'hACE1
`define LFSRMASK       16'hB400

`endif

// File: design/OramPkg.sv
`include "oram_defs.svh"

package OramPkg;

    // ========================================
    // shared vector types
    // ========================================

    // backend and network command code
    typedef logic [`CMDWIDTH-1:0] cmdT;

    // one extra bit so position-map blocks are addressable
    typedef logic [`ORAMU:0] addrT;

    typedef logic [`ORAML-1:0] leafT;

    // position-map block number as data address / 4
    typedef logic [`TAGWIDTH-1:0] tagT;

    typedef logic [`FEDWIDTH-1:0] dataT;

    // front-end FSM
    typedef enum logic [2:0] {
        Idle,
        Lookup,
        Evict,
        Fetch,
        Refill,
        Issue
    } ctrlStateT;

endpackage

// File: design/PlbWay.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module PlbWay #(
    parameter int WayIdx = 0
) (
    input  logic                  Clock,
    input  logic                  rstN,
    input  OramPkg::tagT          LookupTag,
    input  logic                  LeafWrEn,
    input  logic [`LEAFIDXW-1:0]  LeafIdx,
    input  OramPkg::leafT         LeafVal,
    input  logic                  RefillEn,
    input  logic [`WAYIDXW-1:0]   RefillWay,
    input  OramPkg::tagT          RefillTag,
    input  OramPkg::dataT         RefillLeaves,
    output logic                  WayHit,
    output logic                  WayValid,
    output OramPkg::tagT          WayTag,
    output OramPkg::dataT         WayLeaves
);

    logic          valid;
    OramPkg::tagT  tag;
    OramPkg::dataT leaves;
    logic          refillHere;

    assign refillHere = RefillEn && (RefillWay == `WAYIDXW'(WayIdx));

    // tag compare against the broadcast lookup
    assign WayHit    = valid && (tag == LookupTag);
    assign WayValid  = valid;
    assign WayTag    = tag;
    assign WayLeaves = leaves;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            valid <= 1'b0;
        end else if (refillHere) begin
            valid <= 1'b1;
        end
    end

    // refill takes the whole block and a leaf write only touches a hit way
    always_ff @(posedge Clock) begin
        if (refillHere) begin
            tag    <= RefillTag;
            leaves <= RefillLeaves;
        end else if (LeafWrEn && WayHit) begin
            leaves[LeafIdx*`ORAML +: `ORAML] <= LeafVal;
        end
    end

endmodule

// File: design/PlbHitMerge.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module PlbHitMerge (
    input  logic                                Clock,
    input  logic                                rstN,
    input  logic [`PLBWAYS-1:0]                 WayHit,
    input  logic [`PLBWAYS-1:0]                 WayValid,
    input  OramPkg::tagT [`PLBWAYS-1:0]         WayTag,
    input  OramPkg::dataT [`PLBWAYS-1:0]        WayLeaves,
    input  logic                                RefillEn,
    output logic                                Hit,
    output OramPkg::dataT                       HitLeaves,
    output logic [`WAYIDXW-1:0]                 VictimWay,
    output logic                                VictimValid,
    output OramPkg::tagT                        VictimTag,
    output OramPkg::dataT                       VictimLeaves
);

    logic [`WAYIDXW-1:0] victimPtr;

    assign Hit = |WayHit;

    // at most one way hits, so an OR of masked blocks is enough
    always_comb begin
        HitLeaves = '0;
        for (int w = 0; w < `PLBWAYS; w++) begin
            if (WayHit[w]) begin
                HitLeaves = HitLeaves | WayLeaves[w];
            end
        end
    end

    // round robin with one step per refill
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            victimPtr <= '0;
        end else if (RefillEn) begin
            victimPtr <= victimPtr + 1'b1;
        end
    end

    assign VictimWay    = victimPtr;
    assign VictimValid  = WayValid[victimPtr];
    assign VictimTag    = WayTag[victimPtr];
    assign VictimLeaves = WayLeaves[victimPtr];

endmodule

// File: design/FrontEndControl.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module FrontEndControl (
    input  logic                  Clock,
    input  logic                  rstN,
    // network command port
    input  logic                  CmdInValid,
    output logic                  CmdInReady,
    input  OramPkg::cmdT          CmdIn,
    input  logic [`ORAMU-1:0]     ProgAddrIn,
    // backend command port
    output logic                  CmdOutValid,
    input  logic                  CmdOutReady,
    output OramPkg::cmdT          CmdOut,
    output OramPkg::addrT         AddrOut,
    output OramPkg::leafT         OldLeaf,
    output OramPkg::leafT         NewLeaf,
    // feed to the PLB ways
    output OramPkg::tagT          LookupTag,
    output logic                  LeafWrEn,
    output logic [`LEAFIDXW-1:0]  LeafIdx,
    output OramPkg::leafT         LeafVal,
    output logic                  RefillEn,
    output logic [`WAYIDXW-1:0]   RefillWay,
    output OramPkg::tagT          RefillTag,
    output OramPkg::dataT         RefillLeaves,
    // merged PLB state
    input  logic                  Hit,
    input  OramPkg::dataT         HitLeaves,
    input  logic [`WAYIDXW-1:0]   VictimWay,
    input  logic                  VictimValid,
    input  OramPkg::tagT          VictimTag,
    // data path
    output logic                  EvictStore,
    output logic                  DataReq,
    output logic                  IsWrite,
    output logic                  FetchPending,
    input  logic                  RefillValid,
    input  OramPkg::dataT         RefillData,
    input  logic                  Busy
);

    OramPkg::ctrlStateT state;
    OramPkg::cmdT       cmdQ;
    logic [`ORAMU-1:0]  addrQ;
    OramPkg::leafT      leafTable [`PMBLOCKS];
    logic [15:0]        lfsr;
    logic [15:0]        lfsrNext;
    OramPkg::tagT       blockTag;
    logic               cmdXfer;

    assign blockTag    = OramPkg::tagT'(addrQ / `LEAFINBLOCK);
    assign cmdXfer     = CmdOutValid && CmdOutReady;
    assign CmdInReady  = (state == OramPkg::Idle) && !Busy;
    assign CmdOutValid = (state == OramPkg::Evict) || (state == OramPkg::Fetch) ||
                         (state == OramPkg::Issue);

    // galois step taken only when a leaf is consumed
    assign lfsrNext = lfsr[0] ? ((lfsr >> 1) ^ `LFSRMASK) : (lfsr >> 1);

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state <= OramPkg::Idle;
        end else begin
            case (state)
                OramPkg::Idle: begin
                    if (CmdInValid && CmdInReady) begin
                        state <= OramPkg::Lookup;
                    end
                end
                OramPkg::Lookup: begin
                    if (Hit) begin
                        state <= OramPkg::Issue;
                    end else if (VictimValid) begin
                        state <= OramPkg::Evict;
                    end else begin
                        state <= OramPkg::Fetch;
                    end
                end
                OramPkg::Evict: begin
                    if (cmdXfer) begin
                        state <= OramPkg::Fetch;
                    end
                end
                OramPkg::Fetch: begin
                    if (cmdXfer) begin
                        state <= OramPkg::Refill;
                    end
                end
                // back to lookup, which now hits the refilled way
                OramPkg::Refill: begin
                    if (RefillValid) begin
                        state <= OramPkg::Lookup;
                    end
                end
                OramPkg::Issue: begin
                    if (cmdXfer) begin
                        state <= OramPkg::Idle;
                    end
                end
                default: begin
                    state <= OramPkg::Idle;
                end
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (CmdInValid && CmdInReady) begin
            cmdQ  <= CmdIn;
            addrQ <= ProgAddrIn;
        end
    end

    // the append of an evicted block draws no leaf
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            lfsr <= `LFSRSEED;
            for (int i = 0; i < `PMBLOCKS; i++) begin
                leafTable[i] <= '0;
            end
        end else if (cmdXfer && (state != OramPkg::Evict)) begin
            lfsr <= lfsrNext;
            if (state == OramPkg::Fetch) begin
                leafTable[blockTag] <= NewLeaf;
            end
        end
    end

    // ========================================
    // backend command
    // ========================================
    always_comb begin
        CmdOut  = cmdQ;
        AddrOut = OramPkg::addrT'(addrQ);
        OldLeaf = HitLeaves[LeafIdx*`ORAML +: `ORAML];
        NewLeaf = lfsrNext[`ORAML-1:0];
        case (state)
            OramPkg::Evict: begin
                CmdOut  = `CMDAPPEND;
                AddrOut = OramPkg::addrT'(`NUMVALIDBLOCK) + OramPkg::addrT'(VictimTag);
                OldLeaf = leafTable[VictimTag];
                NewLeaf = leafTable[VictimTag];
            end
            OramPkg::Fetch: begin
                CmdOut  = `CMDREADRMV;
                AddrOut = OramPkg::addrT'(`NUMVALIDBLOCK) + OramPkg::addrT'(blockTag);
                OldLeaf = leafTable[blockTag];
            end
            default: begin
            end
        endcase
    end

    // PLB feed
    assign LookupTag    = blockTag;
    assign LeafIdx      = addrQ[`LEAFIDXW-1:0];
    assign LeafVal      = NewLeaf;
    assign LeafWrEn     = (state == OramPkg::Issue) && cmdXfer;
    assign RefillEn     = (state == OramPkg::Refill) && RefillValid;
    assign RefillWay    = VictimWay;
    assign RefillTag    = blockTag;
    assign RefillLeaves = RefillData;

    // data path handoff
    assign EvictStore   = (state == OramPkg::Evict) && cmdXfer;
    assign DataReq      = (state == OramPkg::Issue) && cmdXfer;
    assign IsWrite      = (cmdQ == `CMDWRITE);
    assign FetchPending = (state == OramPkg::Refill);

endmodule

// File: design/UoRamDataPath.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module UoRamDataPath (
    input  logic           Clock,
    input  logic           rstN,
    input  logic           EvictStore,
    input  OramPkg::dataT  VictimLeaves,
    input  logic           DataReq,
    input  logic           IsWrite,
    input  logic           FetchPending,
    // network side
    input  logic           DataInValid,
    output logic           DataInReady,
    input  OramPkg::dataT  DataIn,
    output logic           ReturnDataValid,
    input  logic           ReturnDataReady,
    output OramPkg::dataT  ReturnData,
    // backend side
    output logic           StoreDataValid,
    input  logic           StoreDataReady,
    output OramPkg::dataT  StoreData,
    input  logic           LoadDataValid,
    output logic           LoadDataReady,
    input  OramPkg::dataT  LoadData,
    // to control
    output logic           RefillValid,
    output OramPkg::dataT  RefillData,
    output logic           Busy
);

    OramPkg::dataT storeReg;
    logic          storeValid;
    logic          waitWrite;
    logic          readPending;
    logic          dataInXfer;

    // a write beat waits until any eviction beat has left
    assign DataInReady = waitWrite && !storeValid;
    assign dataInXfer  = DataInValid && DataInReady;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            storeValid  <= 1'b0;
            waitWrite   <= 1'b0;
            readPending <= 1'b0;
        end else begin
            if (EvictStore || dataInXfer) begin
                storeValid <= 1'b1;
            end else if (StoreDataReady) begin
                storeValid <= 1'b0;
            end
            if (DataReq && IsWrite) begin
                waitWrite <= 1'b1;
            end else if (dataInXfer) begin
                waitWrite <= 1'b0;
            end
            if (DataReq && !IsWrite) begin
                readPending <= 1'b1;
            end else if (ReturnDataValid && ReturnDataReady) begin
                readPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (EvictStore) begin
            storeReg <= VictimLeaves;
        end else if (dataInXfer) begin
            storeReg <= DataIn;
        end
    end

    assign StoreDataValid = storeValid;
    assign StoreData      = storeReg;

    // ========================================
    // load steering
    // ========================================
    // position-map beats go to the PLB, which always takes them
    assign RefillValid     = FetchPending && LoadDataValid;
    assign RefillData      = LoadData;
    assign ReturnDataValid = readPending && !FetchPending && LoadDataValid;
    assign ReturnData      = LoadData;
    assign LoadDataReady   = FetchPending || (readPending && ReturnDataReady);

    assign Busy = storeValid || waitWrite || readPending;

endmodule

// File: design/UoRamTop.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module UoRamTop (
    input  logic               Clock,
    input  logic               rstN,
    // network side
    input  logic               CmdInValid,
    output logic               CmdInReady,
    input  OramPkg::cmdT       CmdIn,
    input  logic [`ORAMU-1:0]  ProgAddrIn,
    input  logic               DataInValid,
    output logic               DataInReady,
    input  OramPkg::dataT      DataIn,
    output logic               ReturnDataValid,
    input  logic               ReturnDataReady,
    output OramPkg::dataT      ReturnData,
    // backend side
    output logic               CmdOutValid,
    input  logic               CmdOutReady,
    output OramPkg::cmdT       CmdOut,
    output OramPkg::addrT      AddrOut,
    output OramPkg::leafT      OldLeaf,
    output OramPkg::leafT      NewLeaf,
    output logic               StoreDataValid,
    input  logic               StoreDataReady,
    output OramPkg::dataT      StoreData,
    input  logic               LoadDataValid,
    output logic               LoadDataReady,
    input  OramPkg::dataT      LoadData
);

    // ========================================
    // PLB broadcast and merge nets
    // ========================================
    OramPkg::tagT                 LookupTag;
    logic                         LeafWrEn;
    logic [`LEAFIDXW-1:0]         LeafIdx;
    OramPkg::leafT                LeafVal;
    logic                         RefillEn;
    logic [`WAYIDXW-1:0]          RefillWay;
    OramPkg::tagT                 RefillTag;
    OramPkg::dataT                RefillLeaves;
    logic [`PLBWAYS-1:0]          WayHit;
    logic [`PLBWAYS-1:0]          WayValid;
    OramPkg::tagT [`PLBWAYS-1:0]  WayTag;
    OramPkg::dataT [`PLBWAYS-1:0] WayLeaves;
    logic                         Hit;
    OramPkg::dataT                HitLeaves;
    logic [`WAYIDXW-1:0]          VictimWay;
    logic                         VictimValid;
    OramPkg::tagT                 VictimTag;
    OramPkg::dataT                VictimLeaves;

    // control to data path
    logic                         EvictStore;
    logic                         DataReq;
    logic                         IsWrite;
    logic                         FetchPending;
    logic                         RefillValid;
    OramPkg::dataT                RefillData;
    logic                         Busy;

    FrontEndControl control_i (.*);

    genvar wayIdx;
    generate
        for (wayIdx = 0; wayIdx < `PLBWAYS; wayIdx++) begin : gWay
            PlbWay #(
                .WayIdx       (wayIdx)
            ) way_i (
                .Clock        (Clock),
                .rstN         (rstN),
                .LookupTag    (LookupTag),
                .LeafWrEn     (LeafWrEn),
                .LeafIdx      (LeafIdx),
                .LeafVal      (LeafVal),
                .RefillEn     (RefillEn),
                .RefillWay    (RefillWay),
                .RefillTag    (RefillTag),
                .RefillLeaves (RefillLeaves),
                .WayHit       (WayHit[wayIdx]),
                .WayValid     (WayValid[wayIdx]),
                .WayTag       (WayTag[wayIdx]),
                .WayLeaves    (WayLeaves[wayIdx])
            );
        end
    endgenerate

    PlbHitMerge merge_i (.*);

    UoRamDataPath dataPath_i (.*);

endmodule

// File: verification/UoRamChecker.sv
`timescale 1ns/10ps

module UoRamChecker (
    input logic          Clock,
    input logic          rstN,
    input logic          CmdInReady,
    input logic          CmdOutValid,
    input logic          CmdOutReady,
    input OramPkg::cmdT  CmdOut,
    input OramPkg::addrT AddrOut,
    input OramPkg::leafT OldLeaf,
    input OramPkg::leafT NewLeaf,
    input logic          StoreDataValid,
    input logic          StoreDataReady,
    input OramPkg::dataT StoreData,
    input logic          ReturnDataValid,
    input logic          ReturnDataReady,
    input OramPkg::dataT ReturnData
);

    // ========================================
    // stalled transfers keep valid and payload
    // ========================================
    cmdOutHold: assert property (@(posedge Clock) disable iff (!rstN)
        CmdOutValid && !CmdOutReady |=>
            CmdOutValid && $stable({CmdOut, AddrOut, OldLeaf, NewLeaf}))
        else $error("backend command changed or dropped while stalled");

    storeHold: assert property (@(posedge Clock) disable iff (!rstN)
        StoreDataValid && !StoreDataReady |=> StoreDataValid && $stable(StoreData))
        else $error("store beat changed or dropped while stalled");

    returnHold: assert property (@(posedge Clock) disable iff (!rstN)
        ReturnDataValid && !ReturnDataReady |=> ReturnDataValid && $stable(ReturnData))
        else $error("return beat changed or dropped while stalled");

    // no new program command while a backend command waits
    cmdInBlocked: assert property (@(posedge Clock) disable iff (!rstN)
        CmdOutValid |-> !CmdInReady)
        else $error("command input ready while a backend command is pending");

endmodule

// File: verification/UoRamTb.sv
`timescale 1ns/10ps
`include "oram_defs.svh"

module UoRamTb;

    localparam int MaxLines = 32;

    logic               Clock = 1'b0;
    logic               rstN;
    logic               CmdInValid;
    logic               CmdInReady;
    OramPkg::cmdT       CmdIn;
    logic [`ORAMU-1:0]  ProgAddrIn;
    logic               DataInValid;
    logic               DataInReady;
    OramPkg::dataT      DataIn;
    logic               ReturnDataValid;
    logic               ReturnDataReady;
    OramPkg::dataT      ReturnData;
    logic               CmdOutValid;
    logic               CmdOutReady;
    OramPkg::cmdT       CmdOut;
    OramPkg::addrT      AddrOut;
    OramPkg::leafT      OldLeaf;
    OramPkg::leafT      NewLeaf;
    logic               StoreDataValid;
    logic               StoreDataReady;
    OramPkg::dataT      StoreData;
    logic               LoadDataValid;
    logic               LoadDataReady;
    OramPkg::dataT      LoadData;

    integer             seed = 32'h92517de5;
    logic [31:0]        stimMem [0:3*MaxLines-1];
    int                 numLines = 0;
    int                 checkCount = 0;
    int                 errCount = 0;
    int                 dataReqCount = 0;

    // backend storage for data blocks and position-map blocks
    OramPkg::dataT      dataMem [`NUMVALIDBLOCK] = '{default: '0};
    OramPkg::dataT      pmMem [`PMBLOCKS] = '{default: '0};
    OramPkg::addrT      storeDestQ [$];
    OramPkg::dataT      loadQ [$];

    // reference model of the position map and the PLB tags
    OramPkg::leafT      dataLeaf [`NUMVALIDBLOCK] = '{default: '0};
    OramPkg::leafT      pmLeaf [`PMBLOCKS] = '{default: '0};
    OramPkg::tagT       plbTag [`PLBWAYS];
    logic               plbValid [`PLBWAYS] = '{default: 1'b0};
    logic [1:0]         victimPtr = 2'd0;
    logic [15:0]        refLfsr = `LFSRSEED;

    // expected backend traffic in order
    OramPkg::cmdT       expCmdQ [$];
    OramPkg::addrT      expAddrQ [$];
    OramPkg::leafT      expOldQ [$];
    OramPkg::leafT      expNewQ [$];
    OramPkg::dataT      expStoreQ [$];
    OramPkg::dataT      expRetQ [$];

    UoRamTop dut_i (.*);

    bind UoRamTop UoRamChecker checker_i (
        .Clock(Clock), .rstN(rstN), .CmdInReady(CmdInReady),
        .CmdOutValid(CmdOutValid), .CmdOutReady(CmdOutReady), .CmdOut(CmdOut),
        .AddrOut(AddrOut), .OldLeaf(OldLeaf), .NewLeaf(NewLeaf),
        .StoreDataValid(StoreDataValid), .StoreDataReady(StoreDataReady),
        .StoreData(StoreData), .ReturnDataValid(ReturnDataValid),
        .ReturnDataReady(ReturnDataReady), .ReturnData(ReturnData)
    );

    always #2 Clock = ~Clock;

    // ========================================
    // reference model
    // ========================================
    function automatic OramPkg::leafT drawLeaf();
        if (refLfsr[0]) begin
            refLfsr = (refLfsr >> 1) ^ `LFSRMASK;
        end else begin
            refLfsr = refLfsr >> 1;
        end
        return refLfsr[7:0];
    endfunction

    // leaf 0 sits in the low byte
    function automatic OramPkg::dataT packBlock(input OramPkg::tagT tag);
        return {dataLeaf[{tag, 2'd3}], dataLeaf[{tag, 2'd2}],
                dataLeaf[{tag, 2'd1}], dataLeaf[{tag, 2'd0}]};
    endfunction

    function automatic OramPkg::addrT pmAddr(input OramPkg::tagT tag);
        return OramPkg::addrT'(`NUMVALIDBLOCK + int'(tag));
    endfunction

    task automatic queueCommand(input OramPkg::cmdT cmd, input OramPkg::addrT addr,
                                input OramPkg::leafT oldL, input OramPkg::leafT newL);
        expCmdQ.push_back(cmd);
        expAddrQ.push_back(addr);
        expOldQ.push_back(oldL);
        expNewQ.push_back(newL);
    endtask

    task automatic buildExpect();
        OramPkg::cmdT      cmd;
        logic [`ORAMU-1:0] addr;
        OramPkg::tagT      tag;
        OramPkg::leafT     leaf;
        logic              hit;
        int                i;
        int                w;
        for (i = 0; i < numLines; i++) begin
            cmd  = stimMem[3*i][1:0];
            addr = stimMem[3*i+1][`ORAMU-1:0];
            tag  = addr[`ORAMU-1:2];
            hit  = 1'b0;
            for (w = 0; w < `PLBWAYS; w++) begin
                if (plbValid[w] && plbTag[w] == tag) begin
                    hit = 1'b1;
                end
            end
            if (!hit) begin
                // victim goes back with its own leaf before the fetch
                if (plbValid[victimPtr]) begin
                    queueCommand(`CMDAPPEND, pmAddr(plbTag[victimPtr]),
                                 pmLeaf[plbTag[victimPtr]], pmLeaf[plbTag[victimPtr]]);
                    expStoreQ.push_back(packBlock(plbTag[victimPtr]));
                end
                leaf = drawLeaf();
                queueCommand(`CMDREADRMV, pmAddr(tag), pmLeaf[tag], leaf);
                pmLeaf[tag]         = leaf;
                plbValid[victimPtr] = 1'b1;
                plbTag[victimPtr]   = tag;
                victimPtr           = victimPtr + 2'd1;
            end
            leaf = drawLeaf();
            queueCommand(cmd, {1'b0, addr}, dataLeaf[addr], leaf);
            dataLeaf[addr] = leaf;
            if (cmd == `CMDWRITE) begin
                expStoreQ.push_back(stimMem[3*i+2]);
            end else begin
                expRetQ.push_back(stimMem[3*i+2]);
            end
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal);
        checkCount++;
        assert (gotVal === expVal) else begin
            $display("ERR %s expected %h got %h", name, expVal, gotVal);
            errCount++;
        end
    endtask

    // ========================================
    // backend model and monitors
    // ========================================
    // sampled mid-cycle since the transfer happens on the next rising edge
    always @(negedge Clock) begin : backendMonitor
        OramPkg::addrT dest;
        if (rstN && CmdOutValid && CmdOutReady) begin
            assert (expCmdQ.size() != 0) else begin
                $display("backend command %0d to %0d arrived with none expected", CmdOut, AddrOut);
                errCount++;
            end
            if (expCmdQ.size() != 0) begin
                checkValue("CmdOut", 32'(expCmdQ.pop_front()), 32'(CmdOut));
                checkValue("AddrOut", 32'(expAddrQ.pop_front()), 32'(AddrOut));
                checkValue("OldLeaf", 32'(expOldQ.pop_front()), 32'(OldLeaf));
                checkValue("NewLeaf", 32'(expNewQ.pop_front()), 32'(NewLeaf));
            end
            if (!AddrOut[`ORAMU]) begin
                dataReqCount++;
            end
            if (CmdOut == `CMDAPPEND || CmdOut == `CMDWRITE) begin
                storeDestQ.push_back(AddrOut);
            end else if (AddrOut[`ORAMU]) begin
                loadQ.push_back(pmMem[AddrOut[`TAGWIDTH-1:0]]);
            end else begin
                loadQ.push_back(dataMem[AddrOut[`ORAMU-1:0]]);
            end
        end
        if (rstN && StoreDataValid && StoreDataReady) begin
            assert (storeDestQ.size() != 0 && expStoreQ.size() != 0) else begin
                $display("store beat arrived without a pending write or append");
                errCount++;
            end
            if (storeDestQ.size() != 0 && expStoreQ.size() != 0) begin
                dest = storeDestQ.pop_front();
                if (dest[`ORAMU]) begin
                    pmMem[dest[`TAGWIDTH-1:0]] = StoreData;
                end else begin
                    dataMem[dest[`ORAMU-1:0]] = StoreData;
                end
                checkValue("StoreData", expStoreQ.pop_front(), StoreData);
            end
        end
        if (rstN && ReturnDataValid && ReturnDataReady) begin
            assert (expRetQ.size() != 0) else begin
                $display("return beat arrived with no read outstanding");
                errCount++;
            end
            if (expRetQ.size() != 0) begin
                checkValue("ReturnData", expRetQ.pop_front(), ReturnData);
            end
        end
    end

    // one load beat per queued read after a random delay
    always @(posedge Clock) begin : backendLoad
        int delay;
        if (rstN && loadQ.size() != 0) begin
            delay = $random(seed) & 7;
            repeat (delay) @(posedge Clock);
            LoadData      <= loadQ[0];
            LoadDataValid <= 1'b1;
            do @(negedge Clock); while (!LoadDataReady);
            @(posedge Clock);
            LoadDataValid <= 1'b0;
            void'(loadQ.pop_front());
        end
    end

    always @(posedge Clock) begin
        CmdOutReady     <= ($random(seed) & 3) != 0;
        StoreDataReady  <= ($random(seed) & 3) != 0;
        ReturnDataReady <= ($random(seed) & 3) != 0;
    end

    // ========================================
    // stimulus
    // ========================================
    task automatic sendLine(input int idx);
        @(posedge Clock);
        CmdInValid <= 1'b1;
        CmdIn      <= stimMem[3*idx][1:0];
        ProgAddrIn <= stimMem[3*idx+1][`ORAMU-1:0];
        if (stimMem[3*idx][1:0] == `CMDWRITE) begin
            DataInValid <= 1'b1;
            DataIn      <= stimMem[3*idx+2];
        end
        do @(negedge Clock); while (!CmdInReady);
        @(posedge Clock);
        CmdInValid <= 1'b0;
        if (DataInValid) begin
            do @(negedge Clock); while (!DataInReady);
            @(posedge Clock);
            DataInValid <= 1'b0;
        end
    endtask

    initial begin : mainSeq
        int i;
        int lines;
        rstN            <= 1'b0;
        CmdInValid      <= 1'b0;
        CmdIn           <= '0;
        ProgAddrIn      <= '0;
        DataInValid     <= 1'b0;
        DataIn          <= '0;
        CmdOutReady     <= 1'b0;
        StoreDataReady  <= 1'b0;
        ReturnDataReady <= 1'b0;
        LoadDataValid   <= 1'b0;
        LoadData        <= '0;
        for (i = 0; i < 3 * MaxLines; i++) begin
            stimMem[i] = 32'hFFFF_0000 | 32'(i);
        end
        $readmemh("verification/uoram_stim.txt", stimMem);
        // unused command slots keep the fill with its all-ones upper half
        lines = 0;
        while (lines < MaxLines && stimMem[3*lines][31:16] != 16'hFFFF) begin
            lines++;
        end
        numLines = lines;
        assert (numLines > 0) else begin
            $display("no stimulus lines could be read");
            errCount++;
        end
        buildExpect();
        repeat (16) @(posedge Clock);
        rstN <= 1'b1;
        for (i = 0; i < numLines; i++) begin
            sendLine(i);
        end
        while (expCmdQ.size() != 0 || expStoreQ.size() != 0 || expRetQ.size() != 0) begin
            @(posedge Clock);
        end
        // extra cycles to catch duplicated traffic
        repeat (20) @(posedge Clock);
        assert (dataReqCount == numLines) else begin
            $display("saw %0d data requests for %0d stimulus lines", dataReqCount, numLines);
            errCount++;
        end
        $display("lines %0d checks %0d errors %0d", numLines, checkCount, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (numLines != 0);
        repeat (400 * numLines) @(posedge Clock);
        $display("timeout after %0d cycles, the run did not complete", 400 * numLines);
        $display("lines %0d checks %0d errors %0d", numLines, checkCount, errCount);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: verification/uoram_stim.txt
// columns: command (0 write, 1 read, 2 read-remove), address, data
// data is the write beat for a write and the expected return beat for a read
0 000 11110000
0 001 22220001
1 000 11110000
0 010 33330010
0 020 44440020
1 021 00000000
0 030 55550030
0 040 66660040
1 001 22220001
1 010 33330010
2 020 44440020
0 3ff 77773ff0
1 3ff 77773ff0
1 030 55550030
0 002 88880002
1 002 88880002
1 040 66660040

// File: project.f
+incdir+design
design/OramPkg.sv
design/PlbWay.sv
design/PlbHitMerge.sv
design/FrontEndControl.sv
design/UoRamDataPath.sv
design/UoRamTop.sv
verification/UoRamChecker.sv
verification/UoRamTb.sv

// File: run.sh
#!/bin/sh
# build and run the ORAM front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_LINE="Simulation finished: PASS"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module UoRamTb -o UoRamSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/UoRamSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_LINE" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
